//--- logic/soc_pkg.sv
// Shared memory map, bus widths and region selector for the SoC RTL.
// Modules pull these in with a wildcard import in their header.
`default_nettype none

package soc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 64;
  localparam int unsigned BE_W       = DATA_W / 8;
  localparam int unsigned APB_DATA_W = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [31:0] L2_BASE    = 32'h8000_0000;
  localparam logic [31:0] UART_BASE  = 32'hC000_0000;
  localparam logic [31:0] CTRL_BASE  = 32'hD000_0000;
  // Shared by the UART and control windows
  localparam logic [31:0] PERIPH_LEN = 32'h1000;

  typedef enum logic [1:0] {
    REGION_L2   = 2'd0,
    REGION_UART = 2'd1,
    REGION_CTRL = 2'd2,
    REGION_NONE = 2'd3
  } region_e;

  // Control register offsets within the control window
  localparam logic [11:0] CTRL_EXIT_OFS    = 12'h000;
  localparam logic [11:0] CTRL_CNT_EN_OFS  = 12'h008;
  localparam logic [11:0] CTRL_EVENT_OFS   = 12'h010;
  localparam logic [11:0] CTRL_L2_BASE_OFS = 12'h018;
  localparam logic [11:0] CTRL_L2_END_OFS  = 12'h020;

  // Replace the enabled bytes of a word
  function automatic logic [DATA_W-1:0] be_merge(
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] new_word,
    input logic [BE_W-1:0]   be
  );
    logic [DATA_W-1:0] merged;
    merged = old_word;
    for (int i = 0; i < BE_W; i++) begin
      if (be[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

//--- logic/soc_bus_decoder.sv
// Host-side address decoder. Steers each granted access to L2, the UART
// bridge or the control registers and returns one response per access,
// in acceptance order. Unmapped addresses are answered here with an error.
`default_nettype none

module soc_bus_decoder import soc_pkg::*; #(
  parameter int unsigned L2_WORDS = 1024
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Host port
  input  logic              req_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [BE_W-1:0]   be_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              err_o,
  // Target requests
  output logic              l2_req_o,
  output logic              uart_req_o,
  output logic              ctrl_req_o,
  output logic              tgt_we_o,
  output logic [ADDR_W-1:0] tgt_addr_o,
  output logic [DATA_W-1:0] tgt_wdata_o,
  output logic [BE_W-1:0]   tgt_be_o,
  // Target responses
  input  logic              l2_rvalid_i,
  input  logic [DATA_W-1:0] l2_rdata_i,
  input  logic              uart_rvalid_i,
  input  logic [DATA_W-1:0] uart_rdata_i,
  input  logic              uart_err_i,
  input  logic              uart_ready_i,
  input  logic              ctrl_rvalid_i,
  input  logic [DATA_W-1:0] ctrl_rdata_i,
  input  logic              ctrl_err_i
);

  localparam logic [ADDR_W-1:0] L2_END = L2_BASE + ADDR_W'(L2_WORDS * 8);

  region_e           sel;
  region_e           pend_q;
  logic              busy_q;
  logic              pend_we_q;
  logic              resp_hit;
  logic [DATA_W-1:0] resp_rdata;
  logic              resp_err;
  logic              accept;

  always_comb begin
    if (addr_i >= L2_BASE && addr_i < L2_END) begin
      sel = REGION_L2;
    end else if (addr_i >= UART_BASE && addr_i < UART_BASE + PERIPH_LEN) begin
      sel = REGION_UART;
    end else if (addr_i >= CTRL_BASE && addr_i < CTRL_BASE + PERIPH_LEN) begin
      sel = REGION_CTRL;
    end else begin
      sel = REGION_NONE;
    end
  end

  // Response of the outstanding region
  always_comb begin
    resp_hit   = 1'b0;
    resp_rdata = '0;
    resp_err   = 1'b0;
    case (pend_q)
      REGION_L2: begin
        resp_hit   = l2_rvalid_i;
        resp_rdata = l2_rdata_i;
      end
      REGION_UART: begin
        resp_hit   = uart_rvalid_i;
        resp_rdata = uart_rdata_i;
        resp_err   = uart_err_i;
      end
      REGION_CTRL: begin
        resp_hit   = ctrl_rvalid_i;
        resp_rdata = ctrl_rdata_i;
        resp_err   = ctrl_err_i;
      end
      default: begin
        resp_hit = 1'b1;
        resp_err = 1'b1;
      end
    endcase
  end

  assign rvalid_o = busy_q && resp_hit;
  assign rdata_o  = pend_we_q ? '0 : resp_rdata;
  assign err_o    = resp_err;

  // Only the bridge can refuse a new access
  assign gnt_o  = (!busy_q || resp_hit) && (sel != REGION_UART || uart_ready_i);
  assign accept = req_i && gnt_o;

  assign l2_req_o    = accept && sel == REGION_L2;
  assign uart_req_o  = accept && sel == REGION_UART;
  assign ctrl_req_o  = accept && sel == REGION_CTRL;
  assign tgt_we_o    = we_i;
  assign tgt_addr_o  = addr_i;
  assign tgt_wdata_o = wdata_i;
  assign tgt_be_o    = be_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      pend_q    <= REGION_NONE;
      pend_we_q <= 1'b0;
    end else if (accept) begin
      busy_q    <= 1'b1;
      pend_q    <= sel;
      pend_we_q <= we_i;
    end else if (rvalid_o) begin
      busy_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/l2_mem.sv
// On-chip L2 memory, single port with byte enables.
// Read data and the response strobe arrive one cycle after the request.
`default_nettype none

module l2_mem import soc_pkg::*; #(
  parameter int unsigned L2_WORDS = 1024
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [BE_W-1:0]   be_i,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o
);

  localparam int unsigned IDX_W = $clog2(L2_WORDS);

  logic [DATA_W-1:0] mem [L2_WORDS];
  logic [ADDR_W-1:0] ofs;
  logic [IDX_W-1:0]  idx;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;

  // Word index above the byte offset
  assign ofs = addr_i - L2_BASE;
  assign idx = ofs[IDX_W+2:3];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[idx] <= be_merge(mem[idx], wdata_i, be_i);
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

//--- logic/uart_apb_bridge.sv
// Converts one host access into one APB transfer towards the UART.
// Accepts a request only while idle; ready_o tells the decoder when.
// The 32-bit APB lane is picked by address bit 2.
`default_nettype none

module uart_apb_bridge import soc_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [ADDR_W-1:0]     addr_i,
  input  logic [DATA_W-1:0]     wdata_i,
  input  logic [BE_W-1:0]       be_i,
  output logic                  ready_o,
  output logic                  rvalid_o,
  output logic [DATA_W-1:0]     rdata_o,
  output logic                  err_o,
  // APB master
  output logic                  uart_psel_o,
  output logic                  uart_penable_o,
  output logic                  uart_pwrite_o,
  output logic [ADDR_W-1:0]     uart_paddr_o,
  output logic [APB_DATA_W-1:0] uart_pwdata_o,
  input  logic [APB_DATA_W-1:0] uart_prdata_i,
  input  logic                  uart_pready_i,
  input  logic                  uart_pslverr_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_e;

  state_e                state_q;
  logic                  we_q;
  logic [ADDR_W-1:0]     addr_q;
  logic [APB_DATA_W-1:0] wdata_q;
  logic                  rvalid_q;
  logic [APB_DATA_W-1:0] rdata_q;
  logic                  err_q;
  logic                  done;

  assign done = state_q == ST_ACCESS && uart_pready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= ST_IDLE;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= done;
      case (state_q)
        ST_IDLE: begin
          if (req_i) begin
            state_q <= ST_SETUP;
          end
        end
        ST_SETUP: state_q <= ST_ACCESS;
        ST_ACCESS: begin
          if (uart_pready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && req_i) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= addr_i[2] ? wdata_i[DATA_W-1:APB_DATA_W] : wdata_i[APB_DATA_W-1:0];
    end
    if (done) begin
      rdata_q <= uart_prdata_i;
      err_q   <= uart_pslverr_i;
    end
  end

  assign ready_o  = state_q == ST_IDLE;
  assign rvalid_o = rvalid_q;
  assign rdata_o  = {rdata_q, rdata_q};
  assign err_o    = err_q;

  assign uart_psel_o    = state_q != ST_IDLE;
  assign uart_penable_o = state_q == ST_ACCESS;
  assign uart_pwrite_o  = we_q;
  assign uart_paddr_o   = addr_q;
  assign uart_pwdata_o  = wdata_q;

endmodule

`default_nettype wire

//--- logic/soc_ctrl_regs.sv
// SoC control and status registers: exit code, counter enable and event
// trigger are writable; the L2 base and end addresses are read-only.
// Every request is answered one cycle later.
`default_nettype none

module soc_ctrl_regs import soc_pkg::*; #(
  parameter int unsigned L2_WORDS = 1024
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [BE_W-1:0]   be_i,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              err_o,
  output logic [63:0]       exit_o,
  output logic [63:0]       hw_cnt_en_o,
  output logic [63:0]       event_trigger_o
);

  localparam logic [DATA_W-1:0] L2_END = DATA_W'(L2_BASE) + DATA_W'(L2_WORDS) * 8;

  logic [11:0]       ofs;
  logic [DATA_W-1:0] exit_q;
  logic [DATA_W-1:0] cnt_en_q;
  logic [DATA_W-1:0] event_q;
  logic [DATA_W-1:0] rd_word;
  logic              bad;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;
  logic              err_q;

  assign ofs = addr_i[11:0];

  always_comb begin
    rd_word = '0;
    bad     = 1'b0;
    case (ofs)
      CTRL_EXIT_OFS:   rd_word = exit_q;
      CTRL_CNT_EN_OFS: rd_word = cnt_en_q;
      CTRL_EVENT_OFS:  rd_word = event_q;
      CTRL_L2_BASE_OFS: begin
        rd_word = DATA_W'(L2_BASE);
        bad     = we_i;
      end
      CTRL_L2_END_OFS: begin
        rd_word = L2_END;
        bad     = we_i;
      end
      default: bad = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
      event_q  <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      if (req_i && we_i) begin
        case (ofs)
          CTRL_EXIT_OFS:   exit_q   <= be_merge(exit_q, wdata_i, be_i);
          CTRL_CNT_EN_OFS: cnt_en_q <= be_merge(cnt_en_q, wdata_i, be_i);
          CTRL_EVENT_OFS:  event_q  <= be_merge(event_q, wdata_i, be_i);
          default:         ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= rd_word;
      err_q   <= bad;
    end
  end

  assign rvalid_o        = rvalid_q;
  assign rdata_o         = rdata_q;
  assign err_o           = err_q;
  assign exit_o          = exit_q;
  assign hw_cnt_en_o     = cnt_en_q;
  assign event_trigger_o = event_q;

endmodule

`default_nettype wire

//--- logic/soc_top.sv
// Peripheral SoC top level. One host port with a req/gnt/rvalid handshake
// reaches L2, an APB UART window and the control registers.
// L2_WORDS sets the L2 size and is passed down to every user.
`default_nettype none

module soc_top import soc_pkg::*; #(
  parameter int unsigned L2_WORDS = 1024
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Host port
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [ADDR_W-1:0]     addr_i,
  input  logic [DATA_W-1:0]     wdata_i,
  input  logic [BE_W-1:0]       be_i,
  output logic                  gnt_o,
  output logic                  rvalid_o,
  output logic [DATA_W-1:0]     rdata_o,
  output logic                  err_o,
  // Control outputs
  output logic [63:0]           exit_o,
  output logic [63:0]           hw_cnt_en_o,
  output logic [63:0]           event_trigger_o,
  // UART APB
  output logic                  uart_psel_o,
  output logic                  uart_penable_o,
  output logic                  uart_pwrite_o,
  output logic [ADDR_W-1:0]     uart_paddr_o,
  output logic [APB_DATA_W-1:0] uart_pwdata_o,
  input  logic [APB_DATA_W-1:0] uart_prdata_i,
  input  logic                  uart_pready_i,
  input  logic                  uart_pslverr_i
);

  logic              l2_req;
  logic              uart_req;
  logic              ctrl_req;
  logic              tgt_we;
  logic [ADDR_W-1:0] tgt_addr;
  logic [DATA_W-1:0] tgt_wdata;
  logic [BE_W-1:0]   tgt_be;
  logic              l2_rvalid;
  logic [DATA_W-1:0] l2_rdata;
  logic              uart_rvalid;
  logic [DATA_W-1:0] uart_rdata;
  logic              uart_err;
  logic              uart_ready;
  logic              ctrl_rvalid;
  logic [DATA_W-1:0] ctrl_rdata;
  logic              ctrl_err;

  soc_bus_decoder #(
    .L2_WORDS(L2_WORDS)
  ) i_decoder (
    .clk_i        (clk_i      ),
    .rst_n_i      (rst_n_i    ),
    .req_i        (req_i      ),
    .we_i         (we_i       ),
    .addr_i       (addr_i     ),
    .wdata_i      (wdata_i    ),
    .be_i         (be_i       ),
    .gnt_o        (gnt_o      ),
    .rvalid_o     (rvalid_o   ),
    .rdata_o      (rdata_o    ),
    .err_o        (err_o      ),
    .l2_req_o     (l2_req     ),
    .uart_req_o   (uart_req   ),
    .ctrl_req_o   (ctrl_req   ),
    .tgt_we_o     (tgt_we     ),
    .tgt_addr_o   (tgt_addr   ),
    .tgt_wdata_o  (tgt_wdata  ),
    .tgt_be_o     (tgt_be     ),
    .l2_rvalid_i  (l2_rvalid  ),
    .l2_rdata_i   (l2_rdata   ),
    .uart_rvalid_i(uart_rvalid),
    .uart_rdata_i (uart_rdata ),
    .uart_err_i   (uart_err   ),
    .uart_ready_i (uart_ready ),
    .ctrl_rvalid_i(ctrl_rvalid),
    .ctrl_rdata_i (ctrl_rdata ),
    .ctrl_err_i   (ctrl_err   )
  );

  l2_mem #(
    .L2_WORDS(L2_WORDS)
  ) i_l2 (
    .clk_i   (clk_i    ),
    .rst_n_i (rst_n_i  ),
    .req_i   (l2_req   ),
    .we_i    (tgt_we   ),
    .addr_i  (tgt_addr ),
    .wdata_i (tgt_wdata),
    .be_i    (tgt_be   ),
    .rvalid_o(l2_rvalid),
    .rdata_o (l2_rdata )
  );

  uart_apb_bridge i_uart_bridge (
    .clk_i         (clk_i         ),
    .rst_n_i       (rst_n_i       ),
    .req_i         (uart_req      ),
    .we_i          (tgt_we        ),
    .addr_i        (tgt_addr      ),
    .wdata_i       (tgt_wdata     ),
    .be_i          (tgt_be        ),
    .ready_o       (uart_ready    ),
    .rvalid_o      (uart_rvalid   ),
    .rdata_o       (uart_rdata    ),
    .err_o         (uart_err      ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i)
  );

  soc_ctrl_regs #(
    .L2_WORDS(L2_WORDS)
  ) i_ctrl_regs (
    .clk_i          (clk_i          ),
    .rst_n_i        (rst_n_i        ),
    .req_i          (ctrl_req       ),
    .we_i           (tgt_we         ),
    .addr_i         (tgt_addr       ),
    .wdata_i        (tgt_wdata      ),
    .be_i           (tgt_be         ),
    .rvalid_o       (ctrl_rvalid    ),
    .rdata_o        (ctrl_rdata     ),
    .err_o          (ctrl_err       ),
    .exit_o         (exit_o         ),
    .hw_cnt_en_o    (hw_cnt_en_o    ),
    .event_trigger_o(event_trigger_o)
  );

endmodule

`default_nettype wire

//--- sim/tb_soc.sv
// Testbench for the peripheral SoC top level.
// Host accesses and their expected responses come from the case file. They
// are issued back to back on the req/gnt port, and every response is checked
// in acceptance order. An APB slave model with random wait states answers
// the UART window.
`default_nettype none

module tb_soc import soc_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned L2_WORDS     = 1024;
  localparam int          MAX_CASES    = 64;
  localparam int          GNT_TIMEOUT  = 40;
  localparam int          RESP_TIMEOUT = 40;
  localparam string       CASE_FILE    = "sim/soc_cases.txt";

  logic                  clk_i = 1'b0;
  logic                  rst_n_i;
  logic                  req_i;
  logic                  we_i;
  logic [ADDR_W-1:0]     addr_i;
  logic [DATA_W-1:0]     wdata_i;
  logic [BE_W-1:0]       be_i;
  logic                  gnt_o;
  logic                  rvalid_o;
  logic [DATA_W-1:0]     rdata_o;
  logic                  err_o;
  logic [63:0]           exit_o;
  logic [63:0]           hw_cnt_en_o;
  logic [63:0]           event_trigger_o;
  logic                  uart_psel_o;
  logic                  uart_penable_o;
  logic                  uart_pwrite_o;
  logic [ADDR_W-1:0]     uart_paddr_o;
  logic [APB_DATA_W-1:0] uart_pwdata_o;
  logic [APB_DATA_W-1:0] uart_prdata_i  = '0;
  logic                  uart_pready_i  = 1'b0;
  logic                  uart_pslverr_i = 1'b0;

  // APB slave model state
  logic [31:0]           rng_state      = 32'hed86234b;
  logic [1:0]            wait_left      = '0;
  logic [APB_DATA_W-1:0] apb_last_wdata = '0;
  logic [ADDR_W-1:0]     apb_last_addr  = '0;
  logic                  apb_last_write = 1'b0;

  // Cases and bookkeeping
  logic [7:0]  case_op    [MAX_CASES];
  logic [31:0] case_addr  [MAX_CASES];
  logic [63:0] case_wdata [MAX_CASES];
  logic [7:0]  case_be    [MAX_CASES];
  logic [63:0] case_rdata [MAX_CASES];
  logic        case_err   [MAX_CASES];
  int          n_cases       = 0;
  int          cyc           = 0;
  int          mismatches    = 0;
  int          timeouts      = 0;
  int          protocol_errs = 0;
  int          idx_q [$];
  int          acc_q [$];
  logic [63:0] exit_exp  = '0;
  logic [63:0] cnt_exp   = '0;
  logic [63:0] event_exp = '0;

  always #2 clk_i = ~clk_i;

  soc_top #(
    .L2_WORDS(L2_WORDS)
  ) dut0 (
    .clk_i          (clk_i          ),
    .rst_n_i        (rst_n_i        ),
    .req_i          (req_i          ),
    .we_i           (we_i           ),
    .addr_i         (addr_i         ),
    .wdata_i        (wdata_i        ),
    .be_i           (be_i           ),
    .gnt_o          (gnt_o          ),
    .rvalid_o       (rvalid_o       ),
    .rdata_o        (rdata_o        ),
    .err_o          (err_o          ),
    .exit_o         (exit_o         ),
    .hw_cnt_en_o    (hw_cnt_en_o    ),
    .event_trigger_o(event_trigger_o),
    .uart_psel_o    (uart_psel_o    ),
    .uart_penable_o (uart_penable_o ),
    .uart_pwrite_o  (uart_pwrite_o  ),
    .uart_paddr_o   (uart_paddr_o   ),
    .uart_pwdata_o  (uart_pwdata_o  ),
    .uart_prdata_i  (uart_prdata_i  ),
    .uart_pready_i  (uart_pready_i  ),
    .uart_pslverr_i (uart_pslverr_i )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] mask;
    for (int b = 0; b < BE_W; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic logic in_window(input logic [31:0] addr, input logic [31:0] base);
    return addr[31:12] == base[31:12];
  endfunction

  task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [APB_DATA_W-1:0] got,
                            input logic [APB_DATA_W-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          cnt;
    string       line;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [7:0]  be;
    logic [63:0] rdata;
    logic [3:0]  err;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      protocol_errs++;
      $display("Could not open the case file %s", CASE_FILE);
      return;
    end
    while (!$feof(fd) && n_cases < MAX_CASES) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      cnt = $sscanf(line, "%c %h %h %h %h %h", op, addr, wdata, be, rdata, err);
      if (cnt != 6) begin
        protocol_errs++;
        $display("Could not parse case line: %s", line);
        continue;
      end
      case_op[n_cases]    = op;
      case_addr[n_cases]  = addr;
      case_wdata[n_cases] = wdata;
      case_be[n_cases]    = be;
      case_rdata[n_cases] = rdata;
      case_err[n_cases]   = err[0];
      n_cases++;
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB slave model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      uart_pready_i <= 1'b0;
      wait_left     <= '0;
    end else if (uart_psel_o && !uart_penable_o) begin
      // Pick 0 to 3 wait states at the end of setup
      rng_state       = xorshift32(rng_state);
      wait_left      <= rng_state[1:0];
      uart_pready_i  <= rng_state[1:0] == 2'd0;
      uart_prdata_i  <= uart_paddr_o ^ 32'h5A5A_0000;
      uart_pslverr_i <= uart_paddr_o[11:0] == 12'hFFC;
    end else if (uart_psel_o && uart_penable_o) begin
      if (uart_pready_i) begin
        apb_last_addr  <= uart_paddr_o;
        apb_last_write <= uart_pwrite_o;
        if (uart_pwrite_o) begin
          apb_last_wdata <= uart_pwdata_o;
        end
        uart_pready_i <= 1'b0;
      end else begin
        wait_left     <= wait_left - 2'd1;
        uart_pready_i <= wait_left == 2'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_response(input int i, input int acc);
    logic [31:0] addr;
    addr = case_addr[i];
    check_data($sformatf("rdata_o case %0d", i), rdata_o, case_rdata[i]);
    check_err($sformatf("err_o case %0d", i), err_o, case_err[i]);
    if (in_window(addr, UART_BASE)) begin
      check_word($sformatf("uart_paddr_o case %0d", i), apb_last_addr, addr);
      check_err($sformatf("uart_pwrite_o case %0d", i), apb_last_write,
                case_op[i] == "W");
      if (case_op[i] == "W") begin
        check_word($sformatf("uart_pwdata_o case %0d", i), apb_last_wdata,
                   addr[2] ? case_wdata[i][63:32] : case_wdata[i][31:0]);
      end
    end else if (cyc != acc + 1) begin
      protocol_errs++;
      $display("Case %0d was answered %0d cycles after acceptance instead of 1",
               i, cyc - acc);
    end
    if (in_window(addr, CTRL_BASE) && case_op[i] == "W") begin
      if (!case_err[i]) begin
        case (addr[11:0])
          CTRL_EXIT_OFS:   exit_exp  = merge_bytes(exit_exp, case_wdata[i], case_be[i]);
          CTRL_CNT_EN_OFS: cnt_exp   = merge_bytes(cnt_exp, case_wdata[i], case_be[i]);
          CTRL_EVENT_OFS:  event_exp = merge_bytes(event_exp, case_wdata[i], case_be[i]);
          default:         ;
        endcase
      end
      check_data("exit_o", exit_o, exit_exp);
      check_data("hw_cnt_en_o", hw_cnt_en_o, cnt_exp);
      check_data("event_trigger_o", event_trigger_o, event_exp);
    end
  endtask

  // Outputs are sampled mid-cycle
  always @(negedge clk_i) begin
    int i;
    int acc;
    cyc = cyc + 1;
    if (rst_n_i && rvalid_o) begin
      if (idx_q.size() == 0) begin
        protocol_errs++;
        $display("A response arrived with no access outstanding");
      end else begin
        i   = idx_q.pop_front();
        acc = acc_q.pop_front();
        check_response(i, acc);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_case(input int i);
    req_i   <= 1'b1;
    we_i    <= case_op[i] == "W";
    addr_i  <= case_addr[i];
    wdata_i <= case_wdata[i];
    be_i    <= case_be[i];
  endtask

  task automatic wait_grant(input int i, output bit ok);
    int n;
    n  = 0;
    ok = 1'b1;
    @(negedge clk_i);
    while (!gnt_o && ok) begin
      if (n == GNT_TIMEOUT) begin
        timeouts++;
        ok = 1'b0;
        $display("Timed out waiting for a grant on case %0d", i);
      end else begin
        n++;
        @(negedge clk_i);
      end
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (idx_q.size() != 0 && n < RESP_TIMEOUT) begin
      n++;
      @(posedge clk_i);
    end
    if (idx_q.size() != 0) begin
      timeouts++;
      $display("Timed out waiting for %0d outstanding responses", idx_q.size());
    end
  endtask

  initial begin
    bit ok;
    rst_n_i <= 1'b0;
    req_i   <= 1'b0;
    we_i    <= 1'b0;
    addr_i  <= '0;
    wdata_i <= '0;
    be_i    <= '0;
    load_cases();
    if (n_cases == 0) begin
      protocol_errs++;
      $display("No cases were read from the case file");
    end
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;

    @(negedge clk_i);
    check_data("exit_o", exit_o, '0);
    check_data("hw_cnt_en_o", hw_cnt_en_o, '0);
    check_data("event_trigger_o", event_trigger_o, '0);
    check_err("rvalid_o", rvalid_o, 1'b0);
    check_err("gnt_o", gnt_o, 1'b1);
    check_err("uart_psel_o", uart_psel_o, 1'b0);
    check_err("uart_penable_o", uart_penable_o, 1'b0);

    // Next request goes out on the edge that accepts the previous one
    ok = 1'b1;
    @(posedge clk_i);
    for (int i = 0; i < n_cases && ok; i++) begin
      drive_case(i);
      wait_grant(i, ok);
      if (ok) begin
        @(posedge clk_i);
        idx_q.push_back(i);
        acc_q.push_back(cyc);
      end
    end
    if (!ok) begin
      @(posedge clk_i);
    end
    req_i <= 1'b0;
    wait_drain();

    $display("Errors: %0d mismatches, %0d timeouts, %0d protocol errors",
             mismatches, timeouts, protocol_errs);
    if (mismatches + timeouts + protocol_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/soc_cases.txt
# op addr wdata be exp_rdata exp_err, all hex, op is R or W
# Accesses are issued back to back, responses checked in order
W 80000000 0123456789abcdef ff 0000000000000000 0
W 80000000 aaaaaaaaaaaaaaaa 01 0000000000000000 0
W 80000000 5555555555555555 f0 0000000000000000 0
R 80000000 0000000000000000 00 5555555589abcdaa 0
W 80000008 1122334455667788 ff 0000000000000000 0
W 80000008 ffffffffffffffff 3c 0000000000000000 0
W 80001ff8 cafef00ddeadbeef ff 0000000000000000 0
W 80001ff8 0000000000000000 81 0000000000000000 0
R 80000008 0000000000000000 00 1122ffffffff7788 0
R 80001ff8 0000000000000000 00 00fef00ddeadbe00 0
R 80000000 0000000000000000 00 5555555589abcdaa 0
R 80000008 0000000000000000 00 1122ffffffff7788 0
R d0000000 0000000000000000 00 0000000000000000 0
W d0000000 000000000000002a ff 0000000000000000 0
W d0000008 00000000000000ff 01 0000000000000000 0
W d0000010 1234567800000000 f0 0000000000000000 0
W d0000000 0000000000000100 02 0000000000000000 0
R d0000000 0000000000000000 00 000000000000012a 0
R d0000008 0000000000000000 00 00000000000000ff 0
R d0000018 0000000000000000 00 0000000080000000 0
R d0000020 0000000000000000 00 0000000080002000 0
W d0000018 ffffffffffffffff ff 0000000000000000 1
R d0000018 0000000000000000 00 0000000080000000 0
R d0000028 0000000000000000 00 0000000000000000 1
W c0000000 1111111122222222 ff 0000000000000000 0
W c0000004 3333333344444444 ff 0000000000000000 0
R c0000008 0000000000000000 00 9a5a00089a5a0008 0
R c0000abc 0000000000000000 00 9a5a0abc9a5a0abc 0
R c0000ffc 0000000000000000 00 9a5a0ffc9a5a0ffc 1
W c0000ffc 0123456789abcdef ff 0000000000000000 1
R c0000100 0000000000000000 00 9a5a01009a5a0100 0
R 10000000 0000000000000000 00 0000000000000000 1
W 10000000 ffffffffffffffff ff 0000000000000000 1
R 80002000 0000000000000000 00 0000000000000000 1
R 80000000 0000000000000000 00 5555555589abcdaa 0
R d0000010 0000000000000000 00 1234567800000000 0
R c0000010 0000000000000000 00 9a5a00109a5a0010 0

//--- list.f
logic/soc_pkg.sv
logic/soc_bus_decoder.sv
logic/l2_mem.sv
logic/uart_apb_bridge.sv
logic/soc_ctrl_regs.sv
logic/soc_top.sv
sim/tb_soc.sv

//--- Makefile
# Verilator flow for the peripheral SoC testbench
VERILATOR ?= verilator
TOP       ?= tb_soc
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --timing
PASS_MSG  ?= Verification passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)

# The run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
